//--- dv/mem_test_trace.txt
# W offset data | R offset expected | P offset mask expected | I idle cycles
# all fields hex except the idle count, which is decimal
R 0000 1000010000000000
R 0002 b6e12d9703ac58f1
R 0004 7c2e91a45bd04f38
R 0006 0
W 0020 a5a55a5a12345678
R 0020 a5a55a5a12345678
# write burst of 4 at word 10, then read word 13
W 0040 0a
W 0042 4
W 0046 0123456789abcdef
W 0044 1
I 10
W 0040 0d
W 0042 1
W 0044 3
I 10
R 0048 0123456789abcdef
R 0062 44
R 0062 0
# read burst running past the end of the bank
W 0040 fe
W 0042 4
W 0044 3
I 12
R 0062 60
# bank 1 gets its own word 13
W 0064 1
W 0040 0d
W 0042 1
W 0046 fedcba9876543210
W 0044 1
I 8
W 0044 3
I 8
R 0048 fedcba9876543210
W 0064 0
W 0044 3
I 8
R 0048 0123456789abcdef
R 0062 44
# address tests, 0..99 then 250..259
W 0040 0
W 0042 64
W 004a 1
P 0060 100 100
R 0060 100
W 0040 fa
W 0042 0a
W 004a 1
P 0060 100 100
R 0060 104
R 004a 0

//--- dv/tb_mem_test.sv
// ************************************************************
// testbench for the memory test accelerator host port
// replays dv/mem_test_trace.txt as mmio writes, reads, polls
// and idles, checking each read response and its tag
// ************************************************************
`timescale 1ns/1ns
`default_nettype none

module tb_mem_test;

  localparam int POLL_MAX    = 200;
  localparam int WDOG_PER_OP = 250;    // cycles allowed per trace entry

  logic                Clk_400;
  logic                rst_n;
  mmio_pkg::mmio_req_t mmio_req;
  mmio_pkg::mmio_rsp_t mmio_rsp;

  logic [7:0]  op_q [$];               // trace opcode per entry
  logic [63:0] fa_q [$];               // offset, or idle count
  logic [63:0] fb_q [$];               // data, expected value or mask
  logic [63:0] fc_q [$];               // poll expected value
  int          n_ops;
  int          n_checks;
  int          n_errors;
  logic        trace_ready;
  logic [31:0] rng;                    // tid source

  mem_test_top u_dut (.Clk_400, .rst_n, .mmio_req, .mmio_rsp);

  initial begin
    Clk_400 = 1'b0;
    forever #2 Clk_400 = ~Clk_400;     // 4 ns period
  end

  initial begin
    rst_n <= 1'b0;
    repeat (16) @(posedge Clk_400);
    rst_n <= 1'b1;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // ************************************************************
  // trace loading, '#' lines are notes
  // ************************************************************
  task automatic load_trace(output logic ok);
    int          fd;
    int          code;
    logic [7:0]  op;
    logic [63:0] a, b, c;
    string       skip;
    ok = 1'b0;
    fd = $fopen("dv/mem_test_trace.txt", "r");
    if (fd != 0) begin
      ok = 1'b1;
      while (!$feof(fd)) begin
        code = $fscanf(fd, " %c", op);
        if (code != 1)
          break;                       // end of file
        a = '0;
        b = '0;
        c = '0;
        case (op)
          "#":     code = $fgets(skip, fd);
          "I":     code = $fscanf(fd, "%d", a);        // idle count is decimal
          "P":     code = $fscanf(fd, "%h %h %h", a, b, c);
          default: code = $fscanf(fd, "%h %h", a, b);
        endcase
        if (op != "#") begin
          op_q.push_back(op);
          fa_q.push_back(a);
          fb_q.push_back(b);
          fc_q.push_back(c);
        end
      end
      $fclose(fd);
      n_ops = op_q.size();
    end
  endtask

  // one-cycle write strobe
  task automatic write_reg(input mmio_pkg::mmio_addr_t offs,
                           input mmio_pkg::mmio_data_t data);
    mmio_pkg::mmio_req_t req;
    req          = '0;
    req.wr_valid = 1'b1;
    req.address  = offs;
    req.data     = data;
    @(posedge Clk_400);
    mmio_req <= req;
    @(posedge Clk_400);
    mmio_req <= '0;
  endtask

  // read with a fresh tag, response due in the next cycle only
  task automatic read_reg(input mmio_pkg::mmio_addr_t offs,
                          output mmio_pkg::mmio_data_t data, output logic got);
    mmio_pkg::mmio_req_t req;
    mmio_pkg::mmio_tid_t tid;
    rng          = xorshift32(rng);
    tid          = rng[8:0];
    req          = '0;
    req.rd_valid = 1'b1;
    req.address  = offs;
    req.tid      = tid;
    @(posedge Clk_400);
    mmio_req <= req;
    @(posedge Clk_400);
    mmio_req <= '0;
    @(negedge Clk_400);                // mid response cycle
    data = mmio_rsp.data;
    got  = 1'b0;
    n_checks++;
    if (!mmio_rsp.valid) begin
      $display("no read response came back for offset %h at %0t", offs, $time);
      n_errors++;
    end else if (mmio_rsp.tid != tid) begin
      $display("ERROR %0t: offset %h response tag %h, expected %h",
               $time, offs, mmio_rsp.tid, tid);
      n_errors++;
    end else
      got = 1'b1;
    @(negedge Clk_400);
    if (mmio_rsp.valid) begin          // valid must be a single cycle
      $display("read response for offset %h stayed valid a second cycle", offs);
      n_errors++;
    end
  endtask

  // ************************************************************
  // trace replay
  // ************************************************************
  initial begin
    mmio_pkg::mmio_addr_t offs;
    mmio_pkg::mmio_data_t rdata;
    logic                 got;
    logic                 hit;
    logic                 ok;
    int                   polls;
    mmio_req    <= '0;
    trace_ready = 1'b0;
    n_ops       = 0;
    n_checks    = 0;
    n_errors    = 0;
    rng         = 32'hc784694f;
    load_trace(ok);
    if (!ok) begin
      $display("could not open the trace file dv/mem_test_trace.txt");
      $display("Test failed");
      $finish;
    end else begin
      trace_ready = 1'b1;
      wait (rst_n === 1'b1);
      @(posedge Clk_400);
      for (int i = 0; i < n_ops; i++) begin
        offs = mmio_pkg::mmio_addr_t'(fa_q[i]);
        case (op_q[i])
          "W": write_reg(offs, fb_q[i]);
          "R": begin
            read_reg(offs, rdata, got);
            if (got && rdata != fb_q[i]) begin
              $display("ERROR %0t: offset %h read %h, expected %h",
                       $time, offs, rdata, fb_q[i]);
              n_errors++;
            end
          end
          "P": begin
            hit   = 1'b0;
            polls = 0;
            while (!hit && polls < POLL_MAX) begin
              read_reg(offs, rdata, got);
              polls++;
              if (got && (rdata & fb_q[i]) == fc_q[i])
                hit = 1'b1;
            end
            if (!hit) begin
              $display("offset %h never reached %h under mask %h in %0d polls",
                       offs, fc_q[i], fb_q[i], POLL_MAX);
              n_errors++;
            end
          end
          "I": repeat (fa_q[i]) @(posedge Clk_400);
          default: begin
            $display("trace entry %0d has an unknown opcode %c", i, op_q[i]);
            n_errors++;
          end
        endcase
      end
      repeat (4) @(posedge Clk_400);
      $display("trace entries %0d, checks %0d, errors %0d", n_ops, n_checks, n_errors);
      if (n_errors == 0)
        $display("Test completed successfully");
      else
        $display("Test failed");
      $finish;
    end
  end

  // watchdog sized from the trace length
  initial begin
    wait (trace_ready === 1'b1);
    repeat (n_ops * WDOG_PER_OP) @(posedge Clk_400);
    $display("watchdog expired after %0d cycles, the trace did not finish",
             n_ops * WDOG_PER_OP);
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build the testbench with verilator and run it from the project root
# the run passes only when the pass line shows up in its output
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f vlog.f --top-module tb_mem_test -Mdir obj_dir &&
out=$(./obj_dir/Vtb_mem_test) ; echo "$out" ;
echo "$out" | grep -q "^Test completed successfully$" && exit 0 || exit 1

//--- src/addr_test_engine.sv
// *********************************************************
// address-in-data memory test
// writes each word of the range with its own address, reads
// the range back and counts bad words, saturating at 31
// *********************************************************
`timescale 1ns/1ns
`default_nettype none

module addr_test_engine (
  input  wire                          Clk_400,
  input  wire                          rst_n,
  input  wire                          test_start,
  input  wire mem_test_pkg::avm_addr_t  cmd_addr,
  input  wire mem_test_pkg::avm_burst_t cmd_burst,
  input  wire mem_test_pkg::avm_rsp_t   avm_rsp,
  output mem_test_pkg::avm_req_t       avm_req,
  output logic                         test_done,
  output mem_test_pkg::test_status_t   test_status
);

  typedef enum logic [1:0] {ST_IDLE, ST_WRITE, ST_READ, ST_DRAIN} state_t;

  state_t                     state;
  logic                       rd_q, wr_q;
  mem_test_pkg::avm_addr_t    addr_q;    // beat address
  mem_test_pkg::avm_addr_t    exp_addr;  // address of next returning read
  mem_test_pkg::avm_burst_t   len, len_q, beat_left, rsp_left;
  mem_test_pkg::test_status_t fail_cnt;
  logic                       last_beat, rd_rsp, bad_rd, launch;

  assign len       = (cmd_burst == '0) ? mem_test_pkg::avm_burst_t'(1) : cmd_burst;
  assign last_beat = (beat_left == '0);
  assign launch    = (state == ST_IDLE) && test_start;
  assign rd_rsp    = avm_rsp.readdatavalid && (state == ST_READ || state == ST_DRAIN);
  assign bad_rd    = (avm_rsp.response != mem_test_pkg::RESP_OKAY) ||
                     (avm_rsp.readdata != mem_test_pkg::avm_data_t'(exp_addr));
  // pattern is the address itself, zero-extended
  assign avm_req     = {rd_q, wr_q, addr_q, mem_test_pkg::avm_data_t'(addr_q)};
  assign test_status = fail_cnt;

  always_ff @(posedge Clk_400) begin
    if (!rst_n) begin
      state     <= ST_IDLE;
      rd_q      <= 1'b0;
      wr_q      <= 1'b0;
      beat_left <= '0;
      rsp_left  <= '0;
      fail_cnt  <= '0;
      test_done <= 1'b0;
    end else begin
      test_done <= 1'b0;
      case (state)
        ST_IDLE: if (launch) begin
          state     <= ST_WRITE;
          wr_q      <= 1'b1;
          beat_left <= len - 1'b1;
          fail_cnt  <= '0;
        end
        ST_WRITE: begin
          if (last_beat) begin         // straight into read-back
            wr_q      <= 1'b0;
            rd_q      <= 1'b1;
            beat_left <= len_q - 1'b1;
            rsp_left  <= len_q;
            state     <= ST_READ;
          end else
            beat_left <= beat_left - 1'b1;
        end
        ST_READ: begin
          if (last_beat) begin
            rd_q  <= 1'b0;
            state <= ST_DRAIN;
          end else
            beat_left <= beat_left - 1'b1;
        end
        default: ;                     // drain waits on responses
      endcase
      if (rd_rsp) begin
        rsp_left <= rsp_left - 1'b1;
        if (bad_rd && fail_cnt != '1)
          fail_cnt <= fail_cnt + 1'b1;
        if (rsp_left == mem_test_pkg::avm_burst_t'(1)) begin
          test_done <= 1'b1;
          state     <= ST_IDLE;
        end
      end
    end
  end

  always_ff @(posedge Clk_400) begin
    if (launch) begin
      addr_q   <= cmd_addr;
      exp_addr <= cmd_addr;            // holds the base through the write pass
      len_q    <= len;
    end else if (state == ST_WRITE && last_beat)
      addr_q <= exp_addr;              // rewind for read-back
    else if (rd_q || wr_q)
      addr_q <= addr_q + 1'b1;
    if (rd_rsp)
      exp_addr <= exp_addr + 1'b1;
  end

endmodule

`default_nettype wire

//--- src/avm_burst_master.sv
// *********************************************************
// single-burst master on the memory bus
// one cmd_start pulse runs a read or write burst, done and
// error bits stay set until rdwr_clear
// *********************************************************
`timescale 1ns/1ns
`default_nettype none

module avm_burst_master (
  input  wire                          Clk_400,
  input  wire                          rst_n,
  input  wire                          cmd_start,
  input  wire                          cmd_read,
  input  wire mem_test_pkg::avm_addr_t  cmd_addr,
  input  wire mem_test_pkg::avm_burst_t cmd_burst,
  input  wire mem_test_pkg::avm_data_t  cmd_wrdata,
  input  wire                          rdwr_clear,
  input  wire mem_test_pkg::avm_rsp_t   avm_rsp,
  output mem_test_pkg::avm_req_t       avm_req,
  output logic [1:0]                   rdwr_done,
  output logic [4:0]                   rdwr_status
);

  typedef enum logic [1:0] {ST_IDLE, ST_WRITE, ST_READ} state_t;

  state_t                   state;
  logic                     rd_q, wr_q;      // bus strobes
  mem_test_pkg::avm_addr_t  addr_q;
  mem_test_pkg::avm_data_t  wdata_q;
  mem_test_pkg::avm_burst_t len, beat_left, rsp_left;
  logic                     last_beat, launch;
  logic                     wr_pend, wr_last; // write response due this cycle
  logic [1:0]               wr_err, rd_err;

  assign len         = (cmd_burst == '0) ? mem_test_pkg::avm_burst_t'(1) : cmd_burst;
  assign last_beat   = (beat_left == '0);
  assign launch      = (state == ST_IDLE) && cmd_start; // busy starts are dropped
  assign avm_req     = {rd_q, wr_q, addr_q, wdata_q};
  assign rdwr_status = {1'b0, rd_err, wr_err};          // bit 4 reserved

  // beat issue
  always_ff @(posedge Clk_400) begin
    if (!rst_n) begin
      state     <= ST_IDLE;
      rd_q      <= 1'b0;
      wr_q      <= 1'b0;
      beat_left <= '0;
    end else begin
      case (state)
        ST_IDLE: if (launch) begin
          state     <= cmd_read ? ST_READ : ST_WRITE;
          rd_q      <= cmd_read;
          wr_q      <= !cmd_read;
          beat_left <= len - 1'b1;
        end
        ST_WRITE: begin
          if (last_beat) begin
            wr_q  <= 1'b0;
            state <= ST_IDLE;
          end else
            beat_left <= beat_left - 1'b1;
        end
        ST_READ: begin
          if (rd_q) begin
            if (last_beat) rd_q <= 1'b0;
            else beat_left <= beat_left - 1'b1;
          end
          // stay until the final response is back
          if (avm_rsp.readdatavalid && rsp_left == mem_test_pkg::avm_burst_t'(1))
            state <= ST_IDLE;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // address walks one word per beat, data is held
  always_ff @(posedge Clk_400) begin
    if (launch) begin
      addr_q  <= cmd_addr;
      wdata_q <= cmd_wrdata;
    end else if (rd_q || wr_q)
      addr_q <= addr_q + 1'b1;
  end

  // *********************************************************
  // sticky done and response status
  // *********************************************************
  always_ff @(posedge Clk_400) begin
    if (!rst_n) begin
      rsp_left  <= '0;
      wr_pend   <= 1'b0;
      wr_last   <= 1'b0;
      rdwr_done <= '0;
      wr_err    <= '0;
      rd_err    <= '0;
    end else begin
      wr_pend <= wr_q;
      wr_last <= wr_q && last_beat;
      if (launch)
        rsp_left <= len;
      if (rdwr_clear) begin
        rdwr_done <= '0;
        wr_err    <= '0;
        rd_err    <= '0;
      end
      if (wr_pend)
        wr_err <= wr_err | avm_rsp.response;
      if (wr_last)
        rdwr_done[0] <= 1'b1;          // lands with the last write response
      if (state == ST_READ && avm_rsp.readdatavalid) begin
        rsp_left <= rsp_left - 1'b1;
        rd_err   <= rd_err | avm_rsp.response;
        if (rsp_left == mem_test_pkg::avm_burst_t'(1))
          rdwr_done[1] <= 1'b1;
      end
    end
  end

  a_rd_wr_excl: assert property (@(posedge Clk_400) disable iff (!rst_n)
    !(avm_req.read && avm_req.write));

endmodule

`default_nettype wire

//--- src/mem_bank_model.sv
// *********************************************************
// two-bank on-chip memory behind the avalon-style bus
// writes land in the beat cycle, reads return one cycle later,
// beats past the bank depth get a slave error
// *********************************************************
`timescale 1ns/1ns
`default_nettype none

module mem_bank_model (
  input  wire                        Clk_400,
  input  wire                        rst_n,
  input  wire mem_test_pkg::avm_req_t host_req,
  input  wire mem_test_pkg::avm_req_t test_req,
  input  wire                        port_sel,  // 1 serves the test engine
  input  wire                        bank_sel,
  output mem_test_pkg::avm_rsp_t     rsp
);

  mem_test_pkg::avm_req_t           req;
  logic                             in_range;
  logic [mem_test_pkg::MEM_AW-1:0]  idx;
  mem_test_pkg::avm_data_t          bank0 [mem_test_pkg::MEM_DEPTH];
  mem_test_pkg::avm_data_t          bank1 [mem_test_pkg::MEM_DEPTH];
  logic                             rsp_valid;
  mem_test_pkg::avm_data_t          rsp_data;
  mem_test_pkg::avm_resp_t          rsp_code;

  assign req      = port_sel ? test_req : host_req;
  assign in_range = req.address < mem_test_pkg::avm_addr_t'(mem_test_pkg::MEM_DEPTH);
  assign idx      = req.address[mem_test_pkg::MEM_AW-1:0];
  assign rsp      = {rsp_valid, rsp_data, rsp_code};

  always_ff @(posedge Clk_400) begin
    if (req.write && in_range) begin   // out of range writes dropped
      if (bank_sel) bank1[idx] <= req.writedata;
      else          bank0[idx] <= req.writedata;
    end
    if (req.read)
      rsp_data <= !in_range ? '0 : (bank_sel ? bank1[idx] : bank0[idx]);
  end

  always_ff @(posedge Clk_400) begin
    if (!rst_n) begin
      rsp_valid <= 1'b0;
      rsp_code  <= mem_test_pkg::RESP_OKAY;
    end else begin
      rsp_valid <= req.read;
      rsp_code  <= ((req.read || req.write) && !in_range) ? mem_test_pkg::RESP_SLVERR
                                                          : mem_test_pkg::RESP_OKAY;
    end
  end

endmodule

`default_nettype wire

//--- src/mem_csr.sv
// *********************************************************
// host register file of the memory test accelerator
// decodes mmio writes into engine controls, answers reads
// one cycle later with the tag of the request
// *********************************************************
`timescale 1ns/1ns
`default_nettype none

module mem_csr (
  input  wire                          Clk_400,
  input  wire                          rst_n,
  input  wire mmio_pkg::mmio_req_t     mmio_req,
  output mmio_pkg::mmio_rsp_t          mmio_rsp,
  input  wire mem_test_pkg::avm_rsp_t  avm_rsp,
  input  wire [1:0]                    rdwr_done,   // [0] write, [1] read
  input  wire [4:0]                    rdwr_status,
  input  wire                          test_done,
  input  wire mem_test_pkg::test_status_t test_status,
  output logic                         cmd_start,
  output logic                         cmd_read,
  output mem_test_pkg::avm_addr_t      cmd_addr,
  output mem_test_pkg::avm_burst_t     cmd_burst,
  output mem_test_pkg::avm_data_t      cmd_wrdata,
  output logic                         rdwr_clear,
  output logic                         testmode,
  output logic                         test_start,
  output logic                         bank_sel
);

  mmio_pkg::mmio_data_t scratch_q;
  mmio_pkg::mmio_data_t rddata_q;  // last read beat seen on the bus
  mmio_pkg::mmio_data_t rd_data;   // read mux, sampled with rd_valid
  logic [2:0]           rdwr_q;    // [0] go, [1] read
  logic                 test_done_q;
  logic                 rsp_valid;
  mmio_pkg::mmio_tid_t  rsp_tid;
  mmio_pkg::mmio_data_t rsp_data;

  assign cmd_read = rdwr_q[1];
  assign mmio_rsp = {rsp_valid, rsp_tid, rsp_data};

  // *********************************************************
  // register writes
  // *********************************************************
  always_ff @(posedge Clk_400) begin
    if (!rst_n) begin
      scratch_q   <= '0;
      cmd_addr    <= '0;
      cmd_burst   <= mem_test_pkg::avm_burst_t'(1);
      cmd_wrdata  <= '0;
      rdwr_q      <= '0;
      cmd_start   <= 1'b0;
      testmode    <= 1'b0;
      test_start  <= 1'b0;
      test_done_q <= 1'b0;
      bank_sel    <= 1'b0;
    end else begin
      cmd_start  <= 1'b0;              // pulses
      test_start <= 1'b0;
      if (cmd_start)
        rdwr_q[0] <= 1'b0;             // go bit drops once launched
      if (test_done) begin
        testmode    <= 1'b0;           // test over, hand port back
        test_done_q <= 1'b1;           // sticky until next testmode write
      end
      if (mmio_req.wr_valid) begin
        case (mmio_req.address)
          mmio_pkg::REG_SCRATCH:        scratch_q  <= mmio_req.data;
          mmio_pkg::REG_MEM_ADDRESS:    cmd_addr   <= mmio_req.data[31:0];
          mmio_pkg::REG_MEM_BURSTCOUNT: cmd_burst  <= mmio_req.data[11:0];
          mmio_pkg::REG_MEM_WRDATA:     cmd_wrdata <= mmio_req.data;
          mmio_pkg::REG_MEM_RDWR: begin
            rdwr_q    <= mmio_req.data[2:0];
            cmd_start <= mmio_req.data[0];
          end
          mmio_pkg::REG_TESTMODE: begin
            testmode    <= mmio_req.data[0];
            test_start  <= mmio_req.data[0];
            test_done_q <= 1'b0;
          end
          mmio_pkg::REG_BANK_SELECT:    bank_sel   <= mmio_req.data[0];
          default: ;
        endcase
      end
    end
  end

  // *********************************************************
  // read mux and response
  // *********************************************************
  always_comb begin
    case (mmio_req.address)
      mmio_pkg::REG_DFH:            rd_data = mmio_pkg::DFH_VALUE;
      mmio_pkg::REG_AFU_ID_L:       rd_data = mmio_pkg::AFU_ID_L_VALUE;
      mmio_pkg::REG_AFU_ID_H:       rd_data = mmio_pkg::AFU_ID_H_VALUE;
      mmio_pkg::REG_SCRATCH:        rd_data = scratch_q;
      mmio_pkg::REG_MEM_ADDRESS:    rd_data = {32'd0, cmd_addr};
      mmio_pkg::REG_MEM_BURSTCOUNT: rd_data = {52'd0, cmd_burst};
      mmio_pkg::REG_MEM_RDWR:       rd_data = {61'd0, rdwr_q};
      mmio_pkg::REG_MEM_WRDATA:     rd_data = cmd_wrdata;
      mmio_pkg::REG_MEM_RDDATA:     rd_data = rddata_q;
      mmio_pkg::REG_TESTMODE:       rd_data = {63'd0, testmode};
      mmio_pkg::REG_TEST_STATUS:    rd_data = {55'd0, test_done_q, 3'd0, test_status};
      // rd done, rd err, reserved, wr done, wr err
      mmio_pkg::REG_RDWR_STATUS:    rd_data = {57'd0, rdwr_done[1], rdwr_status[3:2],
                                               rdwr_status[4], rdwr_done[0],
                                               rdwr_status[1:0]};
      mmio_pkg::REG_BANK_SELECT:    rd_data = {63'd0, bank_sel};
      default:                      rd_data = '0; // 0x6, 0x8 and holes
    endcase
  end

  always_ff @(posedge Clk_400) begin
    if (!rst_n) begin
      rsp_valid  <= 1'b0;
      rdwr_clear <= 1'b0;
    end else begin
      rsp_valid  <= mmio_req.rd_valid;
      // status clears behind the response that carried it
      rdwr_clear <= mmio_req.rd_valid && (mmio_req.address == mmio_pkg::REG_RDWR_STATUS);
    end
  end

  always_ff @(posedge Clk_400) begin
    if (mmio_req.rd_valid) begin
      rsp_tid  <= mmio_req.tid;
      rsp_data <= rd_data;
    end
    if (avm_rsp.readdatavalid)
      rddata_q <= avm_rsp.readdata;
  end

  // host never issues a read and a write together
  a_mmio_one_op: assert property (@(posedge Clk_400) disable iff (!rst_n)
    !(mmio_req.wr_valid && mmio_req.rd_valid));

endmodule

`default_nettype wire

//--- src/mem_test_pkg.sv
// *********************************************************
// memory bus types shared by both masters and the memory model
// avalon-style request and response structs, bank depth, codes
// *********************************************************
`default_nettype none

package mem_test_pkg;

  typedef logic [31:0] avm_addr_t;    // word address
  typedef logic [63:0] avm_data_t;
  typedef logic [11:0] avm_burst_t;   // beats per burst, 0 runs as 1
  typedef logic [1:0]  avm_resp_t;
  typedef logic [4:0]  test_status_t; // failure count, saturates

  localparam avm_resp_t RESP_OKAY   = 2'd0;
  localparam avm_resp_t RESP_SLVERR = 2'd2; // address past the bank

  localparam int MEM_DEPTH = 256;           // words per bank
  localparam int MEM_AW    = $clog2(MEM_DEPTH);

  // master to memory, no waitrequest so every beat is taken
  typedef struct packed {
    logic      read;
    logic      write;
    avm_addr_t address;
    avm_data_t writedata;
  } avm_req_t;

  // memory back to master, one cycle behind the beat
  typedef struct packed {
    logic      readdatavalid;
    avm_data_t readdata;
    avm_resp_t response;  // also set for write beats
  } avm_rsp_t;

endpackage

`default_nettype wire

//--- src/mem_test_top.sv
// *********************************************************
// memory test accelerator top, host register port only
// register file, burst master, test engine and memory
// *********************************************************
`timescale 1ns/1ns
`default_nettype none

module mem_test_top (
  input  wire                      Clk_400,
  input  wire                      rst_n,
  input  wire mmio_pkg::mmio_req_t mmio_req,
  output mmio_pkg::mmio_rsp_t      mmio_rsp
);

  mem_test_pkg::avm_req_t     host_req, test_req;
  mem_test_pkg::avm_rsp_t     mem_rsp;       // shared, each master filters
  mem_test_pkg::avm_addr_t    cmd_addr;
  mem_test_pkg::avm_burst_t   cmd_burst;
  mem_test_pkg::avm_data_t    cmd_wrdata;
  mem_test_pkg::test_status_t test_status;
  logic       cmd_start, cmd_read, rdwr_clear;
  logic       testmode, test_start, test_done, bank_sel;
  logic [1:0] rdwr_done;
  logic [4:0] rdwr_status;

  mem_csr u_csr (
    .Clk_400, .rst_n, .mmio_req, .mmio_rsp,
    .avm_rsp (mem_rsp),
    .rdwr_done, .rdwr_status, .test_done, .test_status,
    .cmd_start, .cmd_read, .cmd_addr, .cmd_burst, .cmd_wrdata,
    .rdwr_clear, .testmode, .test_start, .bank_sel
  );

  avm_burst_master u_burst (
    .Clk_400, .rst_n, .cmd_start, .cmd_read, .cmd_addr, .cmd_burst,
    .cmd_wrdata, .rdwr_clear,
    .avm_rsp (mem_rsp),
    .avm_req (host_req),
    .rdwr_done, .rdwr_status
  );

  addr_test_engine u_test (
    .Clk_400, .rst_n, .test_start, .cmd_addr, .cmd_burst,
    .avm_rsp (mem_rsp),
    .avm_req (test_req),
    .test_done, .test_status
  );

  mem_bank_model u_mem (
    .Clk_400, .rst_n, .host_req, .test_req,
    .port_sel (testmode),              // test owns the memory while running
    .bank_sel,
    .rsp      (mem_rsp)
  );

endmodule

`default_nettype wire

//--- src/mmio_pkg.sv
// *********************************************************
// host register port types, register map and identifiers
// offsets count 32-bit units, data is always 64 bits wide
// *********************************************************
`default_nettype none

package mmio_pkg;

  typedef logic [15:0] mmio_addr_t;
  typedef logic [8:0]  mmio_tid_t;   // tag echoed in the response
  typedef logic [63:0] mmio_data_t;

  typedef struct packed {
    logic       wr_valid;            // one-cycle strobes, never both
    logic       rd_valid;
    mmio_addr_t address;
    mmio_tid_t  tid;
    mmio_data_t data;
  } mmio_req_t;

  typedef struct packed {
    logic       valid;
    mmio_tid_t  tid;
    mmio_data_t data;
  } mmio_rsp_t;

  // *********************************************************
  // register map
  // *********************************************************
  localparam mmio_addr_t REG_DFH            = 16'h0000;
  localparam mmio_addr_t REG_AFU_ID_L       = 16'h0002;
  localparam mmio_addr_t REG_AFU_ID_H       = 16'h0004;
  localparam mmio_addr_t REG_SCRATCH        = 16'h0020;
  localparam mmio_addr_t REG_MEM_ADDRESS    = 16'h0040;
  localparam mmio_addr_t REG_MEM_BURSTCOUNT = 16'h0042;
  localparam mmio_addr_t REG_MEM_RDWR       = 16'h0044; // [0] go, [1] read
  localparam mmio_addr_t REG_MEM_WRDATA     = 16'h0046;
  localparam mmio_addr_t REG_MEM_RDDATA     = 16'h0048;
  localparam mmio_addr_t REG_TESTMODE       = 16'h004A;
  localparam mmio_addr_t REG_TEST_STATUS    = 16'h0060;
  localparam mmio_addr_t REG_RDWR_STATUS    = 16'h0062; // clears on read
  localparam mmio_addr_t REG_BANK_SELECT    = 16'h0064;

  // feature type afu in [63:60], end of list at bit 40
  localparam mmio_data_t DFH_VALUE      = {4'h1, 19'd0, 1'b1, 40'd0};
  localparam mmio_data_t AFU_ID_L_VALUE = 64'hB6E1_2D97_03AC_58F1;
  localparam mmio_data_t AFU_ID_H_VALUE = 64'h7C2E_91A4_5BD0_4F38;

endpackage

`default_nettype wire

//--- vlog.f
src/mem_test_pkg.sv
src/mmio_pkg.sv
src/mem_csr.sv
src/avm_burst_master.sv
src/addr_test_engine.sv
src/mem_bank_model.sv
src/mem_test_top.sv
dv/tb_mem_test.sv
